// ==== common/nccMathPkg.sv ====
package nccMathPkg;

	// signed pixel as it arrives from the source
	localparam int pixelWidth = 9;

	// log fraction resolution
	localparam int fracWidth = 16;

	// holds the sum of two pixel exponents plus a fraction carry
	localparam int expWidth = 5;

	localparam int productWidth = 24;
	localparam int scoreWidth = 32;

	typedef logic signed [pixelWidth-1:0] pixel_t;
	typedef logic [fracWidth-1:0] logFrac_t;
	typedef logic [expWidth-1:0] logExp_t;

	// base-2 log of one pixel, Mitchell form
	typedef struct packed {
		logic sign;
		logic zero;
		logExp_t exponent;
		logFrac_t fraction;
	} logNum_t;

	// linear product of one descriptor/window pixel pair
	typedef logic signed [productWidth-1:0] product_t;

	// accumulated window score
	typedef logic signed [scoreWidth-1:0] score_t;

	// no pixel loaded yet, so the product is zero
	localparam logNum_t zeroLog = '{sign: 1'b0, zero: 1'b1, exponent: '0, fraction: '0};

endpackage

// ==== common/nccCtrlPkg.sv ====
package nccCtrlPkg;

	// window index within a frame
	localparam int winIndexWidth = 13;

	// descriptor row pointer, enough for patchDim up to 256
	localparam int rowSelWidth = 8;

	typedef logic [winIndexWidth-1:0] winIndex_t;
	typedef logic [rowSelWidth-1:0] rowSel_t;

	// window handling FSM
	typedef enum logic {
		winIdle,
		winScore
	} winState_t;

endpackage

// ==== design/logConvert.sv ====
`timescale 1ns/1ps

module logConvert (
	input nccMathPkg::pixel_t pixel,
	output nccMathPkg::logNum_t logValue
);

	import nccMathPkg::*;

	logic pixelSign;
	logic [pixelWidth-1:0] magnitude;
	logExp_t leadOne;
	logic [pixelWidth+fracWidth-1:0] aligned;

	assign pixelSign = pixel[pixelWidth-1];

	// -256 still fits as an unsigned 9-bit magnitude
	assign magnitude = pixelSign ? (~pixel + 1'b1) : pixel;

	// leading-one position, highest set bit wins
	always_comb begin
		leadOne = '0;
		for (int b = 0; b < pixelWidth; b++) begin
			if (magnitude[b]) begin
				leadOne = logExp_t'(b);
			end
		end
	end

	// move the leading one up to bit fracWidth so the bits below it
	// land left-aligned in the fraction field
	assign aligned = {{fracWidth{1'b0}}, magnitude} << (fracWidth - leadOne);

	assign logValue.sign = pixelSign;
	assign logValue.zero = (magnitude == '0);
	assign logValue.exponent = leadOne;
	assign logValue.fraction = aligned[fracWidth-1:0];

endmodule

// ==== peArray/processingElement.sv ====
`timescale 1ns/1ps

module processingElement (
	input logic clk,
	input logic rst,
	input nccMathPkg::logNum_t descLog,
	input nccMathPkg::logNum_t winLog,
	input logic loadDesc,
	input logic loadWin,
	input nccMathPkg::score_t sumIn,
	output nccMathPkg::score_t sumOut
);

	import nccMathPkg::*;

	logNum_t descQ;
	logNum_t winQ;
	logExp_t expSum;
	logic [fracWidth:0] fracSum;
	logExp_t prodExp;
	logFrac_t prodFrac;
	logic [productWidth+fracWidth-1:0] linear;
	product_t magnitude;
	product_t product;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descQ <= zeroLog;
			winQ <= zeroLog;
		end else begin
			if (loadDesc) begin
				descQ <= descLog;
			end
			if (loadWin) begin
				winQ <= winLog;
			end
		end
	end

	// log-domain multiply
	assign expSum = descQ.exponent + winQ.exponent;
	assign fracSum = {1'b0, descQ.fraction} + {1'b0, winQ.fraction};

	// fraction overflow moves into the exponent
	assign prodExp = expSum + logExp_t'(fracSum[fracWidth]);
	assign prodFrac = fracSum[fracWidth-1:0];

	// antilog: implicit one at the exponent, fraction below it
	assign linear = {{(productWidth-1){1'b0}}, 1'b1, prodFrac} << prodExp;
	assign magnitude = linear[productWidth+fracWidth-1:fracWidth];

	always_comb begin
		if (descQ.zero || winQ.zero) begin
			product = '0;
		end else if (descQ.sign ^ winQ.sign) begin
			product = -magnitude;
		end else begin
			product = magnitude;
		end
	end

	assign sumOut = sumIn + score_t'(product);

	// both loaded logs together must not push the one-bit out of the product
	assert property (@(posedge clk) disable iff (rst)
		!(descQ.zero || winQ.zero) |-> prodExp < productWidth);

endmodule

// ==== peArray/peArray.sv ====
`timescale 1ns/1ps

module peArray #(
	parameter int patchDim = 4
) (
	input logic clk,
	input logic rst,
	input nccMathPkg::pixel_t [0:patchDim-1] descRow,
	input nccCtrlPkg::rowSel_t descRowSel,
	input logic descWrite,
	input nccMathPkg::pixel_t [0:patchDim*patchDim-1] windowPatch,
	input logic windowLoad,
	output nccMathPkg::score_t patchScore
);

	import nccMathPkg::*;
	import nccCtrlPkg::*;

	logNum_t descLog [patchDim];
	logNum_t winLog [patchDim*patchDim];

	// partial sums along each row, slot 0 is the row's zero input
	score_t rowChain [patchDim][patchDim+1];

	for (genvar c = 0; c < patchDim; c++) begin : gDescConv
		logConvert descConv (
			.pixel(descRow[c]),
			.logValue(descLog[c])
		);
	end

	for (genvar p = 0; p < patchDim*patchDim; p++) begin : gWinConv
		logConvert winConv (
			.pixel(windowPatch[p]),
			.logValue(winLog[p])
		);
	end

	for (genvar r = 0; r < patchDim; r++) begin : gRow
		logic rowWrite;

		// only the PEs of the pointed-to row take the descriptor logs
		assign rowWrite = descWrite && (descRowSel == rowSel_t'(r));
		assign rowChain[r][0] = '0;

		for (genvar c = 0; c < patchDim; c++) begin : gCol
			processingElement pe (
				.clk(clk),
				.rst(rst),
				.descLog(descLog[c]),
				.winLog(winLog[r*patchDim + c]),
				.loadDesc(rowWrite),
				.loadWin(windowLoad),
				.sumIn(rowChain[r][c]),
				.sumOut(rowChain[r][c+1])
			);
		end
	end

	// add up the row totals
	always_comb begin
		patchScore = '0;
		for (int r = 0; r < patchDim; r++) begin
			patchScore = patchScore + rowChain[r][patchDim];
		end
	end

endmodule

// ==== design/loadControl.sv ====
`timescale 1ns/1ps

module loadControl #(
	parameter int patchDim = 4,
	parameter int windowsPerFrame = 4224
) (
	input logic clk,
	input logic rst,
	input logic descReady,
	input logic windowReady,
	output nccCtrlPkg::rowSel_t descRowSel,
	output logic descWrite,
	output logic windowLoad,
	output logic update,
	output logic frameStart,
	output nccCtrlPkg::winIndex_t windowIndex,
	output logic windowDone
);

	import nccCtrlPkg::*;

	winState_t state;
	winState_t nextState;

	// every descReady cycle writes one row
	assign descWrite = descReady;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			descRowSel <= '0;
		end else if (descReady) begin
			if (descRowSel == rowSel_t'(patchDim - 1)) begin
				descRowSel <= '0;
			end else begin
				descRowSel <= descRowSel + 1'b1;
			end
		end
	end

	always_comb begin
		nextState = state;
		windowLoad = 1'b0;
		update = 1'b0;
		case (state)
			winIdle: begin
				if (windowReady) begin
					windowLoad = 1'b1;
					nextState = winScore;
				end
			end
			winScore: begin
				// patch score is valid from the registered logs
				update = 1'b1;
				nextState = winIdle;
			end
			default: nextState = winIdle;
		endcase
	end

	assign frameStart = (windowIndex == '0);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= winIdle;
			windowDone <= 1'b0;
			windowIndex <= '0;
		end else begin
			state <= nextState;
			// done follows the scoring cycle
			windowDone <= (state == winScore);
			if (state == winScore) begin
				if (windowIndex == winIndex_t'(windowsPerFrame - 1)) begin
					windowIndex <= '0;
				end else begin
					windowIndex <= windowIndex + 1'b1;
				end
			end
		end
	end

	// source waits for windowDone before the next window
	assert property (@(posedge clk) disable iff (rst)
		state == winScore |-> !windowReady);

endmodule

// ==== design/bestMatchTracker.sv ====
`timescale 1ns/1ps

module bestMatchTracker (
	input logic clk,
	input logic rst,
	input logic update,
	input logic frameStart,
	input nccMathPkg::score_t score,
	input nccCtrlPkg::winIndex_t windowIndex,
	output nccMathPkg::score_t greatestScore,
	output nccCtrlPkg::winIndex_t greatestIndex
);

	import nccMathPkg::*;

	// magnitudes as unsigned, so the most negative score still compares
	logic [scoreWidth-1:0] newMag;
	logic [scoreWidth-1:0] heldMag;
	logic take;

	assign newMag = score[scoreWidth-1] ? (~score + 1'b1) : score;
	assign heldMag = greatestScore[scoreWidth-1] ? (~greatestScore + 1'b1) : greatestScore;

	// strict compare keeps the earlier window on a tie
	assign take = update && (frameStart || (newMag > heldMag));

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			greatestScore <= '0;
			greatestIndex <= '0;
		end else if (take) begin
			greatestScore <= score;
			greatestIndex <= windowIndex;
		end
	end

endmodule

// ==== design/nccMatcher.sv ====
`timescale 1ns/1ps

module nccMatcher #(
	parameter int patchDim = 4,
	parameter int windowsPerFrame = 4224
) (
	input logic clk,
	input logic rst,
	input logic descReady,
	input nccMathPkg::pixel_t [0:patchDim-1] descRow,
	input logic windowReady,
	input nccMathPkg::pixel_t [0:patchDim*patchDim-1] windowPatch,
	output logic windowDone,
	output nccMathPkg::score_t greatestScore,
	output nccCtrlPkg::winIndex_t greatestIndex
);

	import nccMathPkg::*;
	import nccCtrlPkg::*;

	rowSel_t descRowSel;
	logic descWrite;
	logic windowLoad;
	logic update;
	logic frameStart;
	winIndex_t windowIndex;
	score_t patchScore;

	loadControl #(
		.patchDim(patchDim),
		.windowsPerFrame(windowsPerFrame)
	) ctrl (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.windowReady(windowReady),
		.descRowSel(descRowSel),
		.descWrite(descWrite),
		.windowLoad(windowLoad),
		.update(update),
		.frameStart(frameStart),
		.windowIndex(windowIndex),
		.windowDone(windowDone)
	);

	peArray #(
		.patchDim(patchDim)
	) grid (
		.clk(clk),
		.rst(rst),
		.descRow(descRow),
		.descRowSel(descRowSel),
		.descWrite(descWrite),
		.windowPatch(windowPatch),
		.windowLoad(windowLoad),
		.patchScore(patchScore)
	);

	bestMatchTracker tracker (
		.clk(clk),
		.rst(rst),
		.update(update),
		.frameStart(frameStart),
		.score(patchScore),
		.windowIndex(windowIndex),
		.greatestScore(greatestScore),
		.greatestIndex(greatestIndex)
	);

endmodule

// ==== dv/nccRefModel.svh ====
`ifndef NCC_REF_MODEL_SVH
`define NCC_REF_MODEL_SVH

// exponent is the leading-one position, fraction is the rest scaled to fracWidth bits
function automatic void mitchellLog(input int mag, output int expo, output longint frac);
	expo = 0;
	for (int b = 0; b < pixelWidth; b++) begin
		if (mag >= (1 << b)) begin
			expo = b;
		end
	end
	frac = longint'(mag - (1 << expo)) << (fracWidth - expo);
endfunction

// approximate a*b: add the logs, then take the antilog as an integer
function automatic longint mitchellProduct(input int a, input int b);
	int expA, expB, expSum;
	longint fracA, fracB, fracSum, mag;
	if (a == 0 || b == 0) begin
		return 0;
	end
	mitchellLog(a < 0 ? -a : a, expA, fracA);
	mitchellLog(b < 0 ? -b : b, expB, fracB);
	expSum = expA + expB;
	fracSum = fracA + fracB;
	// fraction overflow bumps the exponent
	if (fracSum >= (longint'(1) << fracWidth)) begin
		expSum = expSum + 1;
		fracSum = fracSum - (longint'(1) << fracWidth);
	end
	mag = (((longint'(1) << fracWidth) + fracSum) << expSum) >> fracWidth;
	return ((a < 0) != (b < 0)) ? -mag : mag;
endfunction

// sum of the pixel products over the whole patch
function automatic int windowScore(input int desc [patchDim][patchDim],
		input int win [patchDim*patchDim]);
	longint sum;
	sum = 0;
	for (int r = 0; r < patchDim; r++) begin
		for (int c = 0; c < patchDim; c++) begin
			sum += mitchellProduct(desc[r][c], win[r*patchDim + c]);
		end
	end
	return int'(sum);
endfunction

// first window of a frame always wins, later ones need a strictly larger magnitude
function automatic bit takesWindow(input int idx, input int newScore, input int heldScore);
	longint newMag, heldMag;
	newMag = (newScore < 0) ? -longint'(newScore) : longint'(newScore);
	heldMag = (heldScore < 0) ? -longint'(heldScore) : longint'(heldScore);
	return (idx == 0) || (newMag > heldMag);
endfunction

`endif

// ==== dv/nccMatcherTb.sv ====
`timescale 1ns/1ps

module nccMatcherTb;

	import nccMathPkg::*;
	import nccCtrlPkg::*;

	localparam int patchDim = 4;
	localparam int windowsPerFrame = 5;
	localparam int doneTimeout = 20;

	`include "nccRefModel.svh"

	logic clk;
	logic rst;
	logic descReady;
	pixel_t [0:patchDim-1] descRow;
	logic windowReady;
	pixel_t [0:patchDim*patchDim-1] windowPatch;
	logic windowDone;
	score_t greatestScore;
	winIndex_t greatestIndex;

	// model of the descriptor, the row pointer and the tracker
	int descModel [patchDim][patchDim];
	int rowPtr;
	int frameIndex;
	score_t expScore;
	winIndex_t expIndex;
	logic [1:0] readyHistory;

	nccMatcher #(
		.patchDim(patchDim),
		.windowsPerFrame(windowsPerFrame)
	) DUT (
		.clk(clk),
		.rst(rst),
		.descReady(descReady),
		.descRow(descRow),
		.windowReady(windowReady),
		.windowPatch(windowPatch),
		.windowDone(windowDone),
		.greatestScore(greatestScore),
		.greatestIndex(greatestIndex)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// done must trail an accepted window by two edges
	always @(posedge clk, posedge rst) begin
		if (rst) begin
			readyHistory <= '0;
		end else begin
			readyHistory <= {readyHistory[0], windowReady};
		end
	end

	assert property (@(posedge clk) disable iff (rst) windowDone == readyHistory[1])
		else failRun($sformatf("MISMATCH at %0t: windowDone expected %0b, got %0b",
			$time, $sampled(readyHistory[1]), $sampled(windowDone)));

	// outputs hold the model values whenever no window is in flight
	assert property (@(posedge clk) disable iff (rst)
		!(windowReady || readyHistory[0]) |-> greatestScore == expScore)
		else failRun($sformatf("MISMATCH at %0t: greatestScore expected %0d, got %0d",
			$time, $sampled(expScore), $sampled(greatestScore)));

	assert property (@(posedge clk) disable iff (rst)
		!(windowReady || readyHistory[0]) |-> greatestIndex == expIndex)
		else failRun($sformatf("MISMATCH at %0t: greatestIndex expected %0d, got %0d",
			$time, $sampled(expIndex), $sampled(greatestIndex)));

	// about one pixel in eight is zero
	function automatic int randomPixel();
		if ($urandom_range(0, 7) == 0) begin
			return 0;
		end
		return int'($urandom_range(0, 510)) - 255;
	endfunction

	task automatic writeRandomRow();
		descReady = 1'b1;
		for (int c = 0; c < patchDim; c++) begin
			descModel[rowPtr][c] = randomPixel();
			descRow[c] = pixel_t'(descModel[rowPtr][c]);
		end
		rowPtr = (rowPtr + 1) % patchDim;
		@(negedge clk);
		descReady = 1'b0;
	endtask

	task automatic waitForDone();
		int cycles;
		cycles = 0;
		while (windowDone !== 1'b1 && cycles < doneTimeout) begin
			@(negedge clk);
			cycles++;
		end
		if (windowDone !== 1'b1) begin
			failRun("windowDone did not rise within the timeout after a window");
		end
		// one idle edge so the new result is seen before the next request
		@(negedge clk);
	endtask

	task automatic sendWindow(input int win [patchDim*patchDim]);
		int score;
		score = windowScore(descModel, win);
		if (takesWindow(frameIndex, score, expScore)) begin
			expScore = score;
			expIndex = winIndex_t'(frameIndex);
		end
		frameIndex = (frameIndex + 1) % windowsPerFrame;
		windowReady = 1'b1;
		for (int p = 0; p < patchDim*patchDim; p++) begin
			windowPatch[p] = pixel_t'(win[p]);
		end
		@(negedge clk);
		windowReady = 1'b0;
		waitForDone();
	endtask

	initial begin
		int win [patchDim*patchDim];
		int base [patchDim*patchDim];
		void'($urandom(32'ha49a31bd));
		rst = 1'b1;
		descReady = 1'b0;
		descRow = '0;
		windowReady = 1'b0;
		windowPatch = '0;
		descModel = '{default: 0};
		rowPtr = 0;
		frameIndex = 0;
		expScore = '0;
		expIndex = '0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (3) @(negedge clk);

		// frame of random windows
		for (int r = 0; r < patchDim; r++) begin
			writeRandomRow();
		end
		for (int w = 0; w < windowsPerFrame; w++) begin
			foreach (win[p]) win[p] = randomPixel();
			sendWindow(win);
		end

		// new rows, small first window, negative winner and ties
		for (int r = 0; r < patchDim; r++) begin
			writeRandomRow();
		end
		win = '{default: 0};
		win[5] = 2;
		sendWindow(win);
		foreach (base[p]) base[p] = randomPixel();
		if (windowScore(descModel, base) > 0) begin
			foreach (base[p]) base[p] = -base[p];
		end
		sendWindow(base);
		foreach (base[p]) base[p] = -base[p];
		sendWindow(base);
		sendWindow(win);
		foreach (base[p]) base[p] = -base[p];
		sendWindow(base);

		// small window at the frame boundary, then rows rewritten between windows
		sendWindow(win);
		for (int w = 1; w < windowsPerFrame; w++) begin
			writeRandomRow();
			foreach (win[p]) win[p] = randomPixel();
			sendWindow(win);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+dv
common/nccMathPkg.sv
common/nccCtrlPkg.sv
design/logConvert.sv
peArray/processingElement.sv
peArray/peArray.sv
design/loadControl.sv
design/bestMatchTracker.sv
design/nccMatcher.sv
dv/nccMatcherTb.sv
